// File: verilog.f
+incdir+tests
source/hc_adder_pkg.sv
source/pg_generate.sv
source/prefix_stage.sv
source/carry_fixup.sv
source/hc_adder_top.sv
tests/tb_hc_adder.sv

// File: tests/tb_checks.svh
/* compare tasks for the adder testbench, included inside tb_hc_adder
   relies on the module's import of hc_adder_pkg for result_t */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

   // ----------------------------------------------------------------------
   // stop on first error
   // ----------------------------------------------------------------------

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1, "stopping at first error");
   endtask

   // ----------------------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------------------

   // sum and carry-out together, x counts as wrong
   task automatic check_result(
      input result_t got,
      input result_t exp,
      input string   what
   );
      if (got !== exp) begin
         abort_run($sformatf(
            "Mismatch at %0d ns: %s sum %h cout %b, expected sum %h cout %b",
            $time, what, got.sum, got.cout, exp.sum, exp.cout));
      end
   endtask

   task automatic check_valid(
      input logic  got,
      input logic  exp,
      input string what
   );
      if (got !== exp) begin
         abort_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
            $time, what, got, exp));
      end
   endtask

`endif

// File: tests/tb_hc_adder.sv
/* directed testbench for hc_adder_top
   inputs change on the falling edge, outputs are sampled on the falling edge
   expected values come from a plain 65-bit addition */

`timescale 1ns/10ps

module tb_hc_adder import hc_adder_pkg::*; ();

   localparam int CLK_PERIOD   = 4;
   localparam int N_RESET_IDLE = 8;
   localparam int N_CORNER     = 9;
   localparam int N_RANDOM     = 200;
   localparam int N_GAP_SLOTS  = 120;
   localparam int N_EDGE       = 12;
   localparam int N_DRAIN      = 6;    // per test, pipeline empties plus idle

   // every driven slot, valid or idle
   localparam int TOTAL_OPS = 2 + 1 + N_RESET_IDLE + 2 * N_CORNER + N_RANDOM
                            + N_GAP_SLOTS + N_EDGE + 4 * N_DRAIN;
   localparam int WATCHDOG_NS = TOTAL_OPS * CLK_PERIOD + 200;

   localparam logic [DATA_W-1:0] ALL_ONES = '1;

   logic     clk = 1'b0;
   logic     rst_n;
   logic     in_valid;
   operand_t operand;
   logic     out_valid;
   result_t  result;

   int       seed = 66;
   result_t  exp_q [$];            // expected results, oldest first
   int       n_pushed  = 0;
   int       n_checked = 0;
   logic     rst_q = 1'b0;         // rst_n as seen by the last rising edge
   logic [1:0] vhist = '0;         // in_valid at the last two rising edges

   `include "tb_checks.svh"

   hc_adder_top i_hc_adder_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .operand   (operand),
      .out_valid (out_valid),
      .result    (result)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ----------------------------------------------------------------------
   // reference model and stimulus helpers
   // ----------------------------------------------------------------------

   function automatic result_t expected_sum(
      input logic [DATA_W-1:0] a,
      input logic [DATA_W-1:0] b,
      input logic              cin
   );
      logic [DATA_W:0] total;
      result_t         r;
      total  = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, cin};
      r.sum  = total[DATA_W-1:0];
      r.cout = total[DATA_W];
      return r;
   endfunction

   function automatic logic [DATA_W-1:0] rand_word();
      return {$random(seed), $random(seed)};
   endfunction

   task automatic drive_operand(
      input logic [DATA_W-1:0] a,
      input logic [DATA_W-1:0] b,
      input logic              cin
   );
      @(negedge clk);
      operand.a   = a;
      operand.b   = b;
      operand.cin = cin;
      in_valid    = 1'b1;
      exp_q.push_back(expected_sum(a, b, cin));
      n_pushed++;
   endtask

   // idle cycles carry junk operands, the DUT must ignore them
   task automatic drive_idle(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         in_valid    = 1'b0;
         operand.a   = rand_word();
         operand.b   = rand_word();
         operand.cin = $random(seed);
      end
   endtask

   // one operand followed by an idle slot
   task automatic drive_spaced(
      input logic [DATA_W-1:0] a,
      input logic [DATA_W-1:0] b,
      input logic              cin
   );
      drive_operand(a, b, cin);
      drive_idle(1);
   endtask

   task automatic drain_results();
      while (exp_q.size() != 0) begin
         drive_idle(1);
      end
      drive_idle(2);   // no late results
   endtask

   // ----------------------------------------------------------------------
   // output monitor
   // ----------------------------------------------------------------------

   always @(posedge clk) begin
      rst_q = rst_n;
      vhist = {vhist[0], in_valid};
   end

   // out_valid repeats in_valid two cycles after it was driven
   always @(negedge clk) begin
      if (rst_q) begin
         check_valid(out_valid, vhist[1], "out_valid");
         if (out_valid) begin
            if (exp_q.size() == 0) begin
               abort_run("out_valid went high with no result outstanding");
            end else begin
               check_result(result, exp_q.pop_front(), "result");
               n_checked++;
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // tests
   // ----------------------------------------------------------------------

   task automatic test_reset_idle();
      drive_idle(1);
      check_result(result, '0, "result after reset");
      check_valid(out_valid, 1'b0, "out_valid after reset");
      drive_idle(N_RESET_IDLE);   // monitor sees out_valid low throughout
   endtask

   task automatic test_corners();
      drive_spaced(ALL_ONES, 64'd1, 1'b0);
      drive_spaced(ALL_ONES, '0, 1'b1);
      drive_spaced('0, '0, 1'b0);
      drive_spaced('0, '0, 1'b1);
      drive_spaced(64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555, 1'b0);
      drive_spaced(64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555, 1'b1);
      drive_spaced(64'h5555_5555_5555_5555, 64'h5555_5555_5555_5555, 1'b1);
      // propagate everywhere, cin has to travel through all groups
      drive_spaced(64'h8888_8888_8888_8888, 64'h7777_7777_7777_7777, 1'b1);
      drive_spaced(64'h7FFF_FFFF_FFFF_FFFF, 64'd1, 1'b0);
      drain_results();
   endtask

   task automatic test_back_to_back();
      int start;
      start = n_checked;
      for (int i = 0; i < N_RANDOM; i++) begin
         drive_operand(rand_word(), rand_word(), $random(seed));
      end
      drain_results();
      if (n_checked - start != N_RANDOM) begin
         abort_run($sformatf("back-to-back run returned %0d results instead of %0d",
            n_checked - start, N_RANDOM));
      end
   endtask

   task automatic test_valid_gaps();
      for (int i = 0; i < N_GAP_SLOTS; i++) begin
         if (($random(seed) & 3) == 0) begin
            drive_idle(1);
         end else begin
            drive_operand(rand_word(), rand_word(), $random(seed));
         end
      end
      drain_results();
   endtask

   // sums on either side of 2**64
   task automatic test_carry_out_edge();
      for (int k = 0; k < N_EDGE / 3; k++) begin
         drive_operand(ALL_ONES - k, k, 1'b0);       // exactly max, no carry
         drive_operand(ALL_ONES - k, k, 1'b1);       // one over
         drive_operand(ALL_ONES - k, k + 1, 1'b0);   // one over
      end
      drain_results();
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------

   initial begin
      rst_n    = 1'b0;
      in_valid = 1'b0;
      operand  = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      test_reset_idle();
      test_corners();
      test_back_to_back();
      test_valid_gaps();
      test_carry_out_edge();

      if (n_checked != n_pushed) begin
         abort_run($sformatf("%0d operands sent but %0d results checked",
            n_pushed, n_checked));
      end else begin
         $display("Regression passed");
         $finish;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      abort_run("watchdog expired before the tests finished");
   end

endmodule

// File: source/hc_adder_top.sv
/* 64-bit hybrid brent-kung / kogge-stone adder, 2 cycle latency
   one operand per cycle, no back-pressure, results leave in order */

`timescale 1ns/10ps

module hc_adder_top import hc_adder_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   input  operand_t operand,
   output logic     out_valid,
   output result_t  result
);

   operand_t op_q;
   logic     valid_q;

   gp_vec_t  level_gp [PREFIX_LEVELS+1];   // [0] from pg_generate, last into fixup
   top_gp_t  msb_gp;
   result_t  sum_d;

   // ----------------------------------------------------------------------
   // input register
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         op_q <= operand;   // holds while idle
      end
   end

   // ----------------------------------------------------------------------
   // generate/propagate
   // ----------------------------------------------------------------------

   pg_generate i_pg_generate (
      .operand (op_q),
      .gp      (level_gp[0]),
      .msb_gp  (msb_gp)
   );

   // ----------------------------------------------------------------------
   // prefix tree
   // ----------------------------------------------------------------------

   // first BK_LEVELS levels build groups, stride doubles with the distance
   // remaining levels stay at group stride and double the distance only
   for (genvar k = 0; k < PREFIX_LEVELS; k++) begin : g_level
      localparam int DIST   = 2 ** k;
      localparam int STRIDE = (2 * DIST < GROUP_W) ? 2 * DIST : GROUP_W;

      prefix_stage #(
         .DIST   (DIST),
         .STRIDE (STRIDE)
      ) i_prefix_stage (
         .gp_in  (level_gp[k]),
         .gp_out (level_gp[k+1])
      );
   end

   // ----------------------------------------------------------------------
   // fix-up and output register
   // ----------------------------------------------------------------------

   carry_fixup i_carry_fixup (
      .tree_gp (level_gp[PREFIX_LEVELS]),
      .base_gp (level_gp[0]),
      .msb_gp  (msb_gp),
      .result  (sum_d)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         result    <= '0;
      end else begin
         out_valid <= valid_q;
         if (valid_q) begin
            result <= sum_d;   // keeps last sum on idle cycles
         end
      end
   end

endmodule

// File: source/carry_fixup.sv
/* completes the carries the sparse tree leaves out and forms the sum
   expects tree_gp to have every column 4j+3 complete down to column 0
   tied to GROUP_W = 4 with two brent-kung levels */

`timescale 1ns/10ps

module carry_fixup import hc_adder_pkg::*; (
   input  gp_vec_t tree_gp,    // after the last prefix level
   input  gp_vec_t base_gp,    // straight from pg_generate
   input  top_gp_t msb_gp,
   output result_t result
);

   localparam int N_GROUPS = DATA_W / GROUP_W;

   // carry[i] is the carry into operand bit i, i.e. G over columns i..0
   logic [DATA_W-1:0] carry;
   logic [DATA_W-1:0] op_p;    // propagate of operand bits, realigned

   // ----------------------------------------------------------------------
   // carry completion
   // ----------------------------------------------------------------------

   always_comb begin
      // columns 0, 1 and every 4j+3 are already final
      carry = tree_gp.g;

      // rank 1
      // column 4j+1 holds its level-1 pair, extend with 4j-1
      for (int j = 1; j < N_GROUPS; j++) begin
         carry[GROUP_W*j + 1] = tree_gp.g[GROUP_W*j + 1]
                              | (tree_gp.p[GROUP_W*j + 1] & tree_gp.g[GROUP_W*j - 1]);
      end

      // rank 2
      // even columns take one bit on top of the carry below
      for (int j = 1; j < N_GROUPS; j++) begin
         carry[GROUP_W*j] = base_gp.g[GROUP_W*j]
                          | (base_gp.p[GROUP_W*j] & tree_gp.g[GROUP_W*j - 1]);
      end
      for (int j = 0; j < N_GROUPS; j++) begin
         carry[GROUP_W*j + 2] = base_gp.g[GROUP_W*j + 2]
                              | (base_gp.p[GROUP_W*j + 2] & carry[GROUP_W*j + 1]);
      end
   end

   // ----------------------------------------------------------------------
   // sum and carry-out
   // ----------------------------------------------------------------------

   // column i+1 holds operand bit i, msb comes in separately
   assign op_p = {msb_gp.p, base_gp.p[DATA_W-1:1]};

   assign result.sum  = op_p ^ carry;
   assign result.cout = msb_gp.g | (msb_gp.p & carry[DATA_W-1]);

endmodule

// File: source/prefix_stage.sv
/* one level of the prefix tree, combinational
   a column is active when (c+1) is a multiple of STRIDE and c >= DIST
   DIST must be below DATA_W and STRIDE must be nonzero */

`timescale 1ns/10ps

module prefix_stage import hc_adder_pkg::*; #(
   parameter int DIST   = 1,
   parameter int STRIDE = 2
) (
   input  gp_vec_t gp_in,
   output gp_vec_t gp_out
);

   // ----------------------------------------------------------------------
   // active column mask, fixed at elaboration
   // ----------------------------------------------------------------------

   function automatic logic [DATA_W-1:0] active_mask();
      logic [DATA_W-1:0] mask;
      mask = '0;
      for (int c = DIST; c < DATA_W; c++) begin
         mask[c] = ((c + 1) % STRIDE) == 0;
      end
      return mask;
   endfunction

   localparam logic [DATA_W-1:0] ACTIVE = active_mask();

   // ----------------------------------------------------------------------
   // prefix operator
   // ----------------------------------------------------------------------

   // upper span (c) over lower span (c-DIST):
   //   g = g_hi | p_hi & g_lo
   //   p = p_hi & p_lo
   always_comb begin
      gp_out = gp_in;   // idle columns copy through
      for (int c = DIST; c < DATA_W; c++) begin
         if (ACTIVE[c]) begin
            gp_out.g[c] = gp_in.g[c] | (gp_in.p[c] & gp_in.g[c - DIST]);
            gp_out.p[c] = gp_in.p[c] & gp_in.p[c - DIST];
         end
      end
   end

endmodule

// File: source/pg_generate.sv
/* per-bit generate and propagate, purely combinational
   columns are shifted up by one so column 0 carries cin */

`timescale 1ns/10ps

module pg_generate import hc_adder_pkg::*; (
   input  operand_t operand,
   output gp_vec_t  gp,
   output top_gp_t  msb_gp
);

   logic [DATA_W-1:0] bit_g;
   logic [DATA_W-1:0] bit_p;

   // ----------------------------------------------------------------------
   // bitwise terms
   // ----------------------------------------------------------------------

   assign bit_g = operand.a & operand.b;   // carry made here
   assign bit_p = operand.a ^ operand.b;   // carry passed through

   // ----------------------------------------------------------------------
   // column mapping
   // ----------------------------------------------------------------------

   // cin sits below bit 0 as a pure generate
   assign gp.g = {bit_g[DATA_W-2:0], operand.cin};
   assign gp.p = {bit_p[DATA_W-2:0], 1'b0};

   // msb falls off the top of the column range
   // only needed for its own sum bit and the carry-out
   assign msb_gp.g = bit_g[DATA_W-1];
   assign msb_gp.p = bit_p[DATA_W-1];

endmodule

// File: source/hc_adder_pkg.sv
/* shared types for the 64-bit hybrid prefix adder
   width is fixed here, DATA_W must be a power of two multiple of GROUP_W */

package hc_adder_pkg;

   // ----------------------------------------------------------------------
   // sizes
   // ----------------------------------------------------------------------

   localparam int DATA_W  = 64;   // operand width
   localparam int GROUP_W = 4;    // brent-kung group size

   // two brent-kung levels build groups of four
   localparam int BK_LEVELS = 2;

   // kogge-stone spans the groups, log2 of the group count
   localparam int KS_LEVELS = $clog2(DATA_W / GROUP_W);

   localparam int PREFIX_LEVELS = BK_LEVELS + KS_LEVELS;

   // ----------------------------------------------------------------------
   // packed types
   // ----------------------------------------------------------------------

   // adder input, 129 bits
   typedef struct packed {
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      logic              cin;
   } operand_t;

   // adder output, 65 bits
   typedef struct packed {
      logic [DATA_W-1:0] sum;
      logic              cout;
   } result_t;

   // generate/propagate per prefix column
   // column 0 is the carry-in (g = cin, p = 0), column c holds operand bit c-1
   typedef struct packed {
      logic [DATA_W-1:0] g;
      logic [DATA_W-1:0] p;
   } gp_vec_t;

   // top operand bit, shifted out of the prefix columns
   typedef struct packed {
      logic g;
      logic p;
   } top_gp_t;

endpackage
